// ==== rtl/msrh_params.svh ====
`ifndef MSRH_PARAMS_SVH
`define MSRH_PARAMS_SVH

// ======================================================================
// Core sizes
// ======================================================================
`define MSRH_DISP_SIZE      2
`define MSRH_MEM_DISP_SIZE  2
`define MSRH_STQ_SIZE       8

// ======================================================================
// Field widths
// ======================================================================
`define MSRH_CMT_ID_W       6
`define MSRH_REG_TAG_W      6
`define MSRH_ADDR_W         32
`define MSRH_DATA_W         32

`endif

// ==== rtl/msrh_pkg.sv ====
`include "msrh_params.svh"

package msrh_pkg;

  // One slot of a dispatch group
  typedef struct packed {
    logic                        store;
    logic [`MSRH_REG_TAG_W-1:0]  reg_tag;
  } disp_t;

  typedef struct packed {
    disp_t [`MSRH_DISP_SIZE-1:0] inst;
    logic [`MSRH_CMT_ID_W-1:0]   cmt_id;
  } disp_grp_t;

  // Sent into the LSU pipe on replay
  typedef struct packed {
    logic [`MSRH_CMT_ID_W-1:0]   cmt_id;
    logic [`MSRH_DISP_SIZE-1:0]  grp_id;
    logic [`MSRH_REG_TAG_W-1:0]  reg_tag;
    logic [`MSRH_STQ_SIZE-1:0]   oh_idx;
  } issue_t;

  // grp_id is the mask of committed slots
  typedef struct packed {
    logic                        valid;
    logic [`MSRH_CMT_ID_W-1:0]   cmt_id;
    logic [`MSRH_DISP_SIZE-1:0]  grp_id;
  } commit_blk_t;

  typedef struct packed {
    logic                        valid;
    logic [`MSRH_CMT_ID_W-1:0]   cmt_id;
    logic [`MSRH_DISP_SIZE-1:0]  grp_id;
    logic                        exc_vld;
  } done_rpt_t;

endpackage

// ==== rtl/msrh_lsu_pkg.sv ====
`include "msrh_params.svh"

package msrh_lsu_pkg;

  typedef enum logic [2:0] {
    INIT,
    READY,
    ISSUED,
    ADDR_DONE,
    WAIT_COMMIT,
    COMMIT
  } stq_state_t;

  typedef struct packed {
    stq_state_t                  state;
    logic [`MSRH_CMT_ID_W-1:0]   cmt_id;
    logic [`MSRH_DISP_SIZE-1:0]  grp_id;
    msrh_pkg::issue_t            inst;
    logic [`MSRH_ADDR_W-1:0]     addr;
    logic [`MSRH_DATA_W-1:0]     data;
  } stq_entry_t;

  // Result from LSU pipe EX2 for the entry in index_oh
  typedef struct packed {
    logic                        valid;
    logic [`MSRH_STQ_SIZE-1:0]   index_oh;
    logic                        tlb_miss;
    logic [`MSRH_ADDR_W-1:0]     addr;
    logic [`MSRH_DATA_W-1:0]     data;
  } ex2_q_update_t;

  typedef struct packed {
    logic                        valid;
    logic [`MSRH_ADDR_W-1:0]     addr;
    logic [`MSRH_DATA_W-1:0]     data;
  } drain_req_t;

  typedef struct packed {
    logic [`MSRH_ADDR_W-1:0]     paddr;
    logic [`MSRH_DATA_W-1:0]     pwdata;
    logic                        psel;
    logic                        penable;
    logic                        pwrite;
  } apb_req_t;

endpackage

// ==== rtl/msrh_disp_pickup.sv ====
`timescale 1ns/1ps
`include "msrh_params.svh"

module msrh_disp_pickup (
  input  logic [`MSRH_DISP_SIZE-1:0]     i_disp_valid,
  input  msrh_pkg::disp_grp_t            i_disp,
  output logic [`MSRH_MEM_DISP_SIZE-1:0] o_pick_valid,
  output msrh_pkg::disp_t                o_pick[`MSRH_MEM_DISP_SIZE],
  output logic [`MSRH_DISP_SIZE-1:0]     o_pick_grp_id[`MSRH_MEM_DISP_SIZE]
);

  // Pack valid stores into the lowest free write ports, in slot order
  always_comb begin
    int port;
    port = 0;
    o_pick_valid = '0;
    for (int p = 0; p < `MSRH_MEM_DISP_SIZE; p++) begin
      o_pick[p]        = '0;
      o_pick_grp_id[p] = '0;
    end
    for (int s = 0; s < `MSRH_DISP_SIZE; s++) begin
      if (i_disp_valid[s] && i_disp.inst[s].store && (port < `MSRH_MEM_DISP_SIZE)) begin
        o_pick_valid[port]     = 1'b1;
        o_pick[port]           = i_disp.inst[s];
        // slot position becomes the one-hot group id
        o_pick_grp_id[port]    = '0;
        o_pick_grp_id[port][s] = 1'b1;
        port = port + 1;
      end
    end
  end

endmodule

// ==== rtl/msrh_stq_entry.sv ====
`timescale 1ns/1ps
`include "msrh_params.svh"

module msrh_stq_entry (
  input  logic                        i_clk,
  input  logic                        i_reset_n,

  input  logic                        i_disp_load,
  input  logic [`MSRH_CMT_ID_W-1:0]   i_disp_cmt_id,
  input  logic [`MSRH_DISP_SIZE-1:0]  i_disp_grp_id,
  input  msrh_pkg::disp_t             i_disp,
  input  logic [`MSRH_STQ_SIZE-1:0]   i_queue_index,

  input  logic                        i_replay_accept,
  input  logic                        i_ex2_valid,
  input  msrh_lsu_pkg::ex2_q_update_t i_ex2_update,
  input  logic                        i_done_taken,
  input  msrh_pkg::commit_blk_t       i_commit,
  input  logic                        i_drain_taken,

  output msrh_lsu_pkg::stq_entry_t    o_entry
);

  msrh_lsu_pkg::stq_state_t r_state;
  msrh_pkg::issue_t         r_inst;
  logic [`MSRH_ADDR_W-1:0]  r_addr;
  logic [`MSRH_DATA_W-1:0]  r_data;
  logic                     w_commit_hit;

  assign w_commit_hit = i_commit.valid && (i_commit.cmt_id == r_inst.cmt_id) &&
                        |(i_commit.grp_id & r_inst.grp_id);

  // ======================================================================
  // Entry state machine
  // ======================================================================
  always_ff @(posedge i_clk) begin
    if (!i_reset_n) begin
      r_state <= msrh_lsu_pkg::INIT;
    end else begin
      unique case (r_state)
        msrh_lsu_pkg::INIT: begin
          if (i_disp_load) r_state <= msrh_lsu_pkg::READY;
        end
        msrh_lsu_pkg::READY: begin
          if (i_replay_accept) r_state <= msrh_lsu_pkg::ISSUED;
        end
        msrh_lsu_pkg::ISSUED: begin
          // TLB miss goes back for another replay
          if (i_ex2_valid) begin
            r_state <= i_ex2_update.tlb_miss ? msrh_lsu_pkg::READY : msrh_lsu_pkg::ADDR_DONE;
          end
        end
        msrh_lsu_pkg::ADDR_DONE: begin
          if (i_done_taken) r_state <= msrh_lsu_pkg::WAIT_COMMIT;
        end
        msrh_lsu_pkg::WAIT_COMMIT: begin
          if (w_commit_hit) r_state <= msrh_lsu_pkg::COMMIT;
        end
        msrh_lsu_pkg::COMMIT: begin
          if (i_drain_taken) r_state <= msrh_lsu_pkg::INIT;
        end
        default: r_state <= msrh_lsu_pkg::INIT;
      endcase
    end
  end

  // Payload capture
  always_ff @(posedge i_clk) begin
    if (i_disp_load) begin
      r_inst.cmt_id  <= i_disp_cmt_id;
      r_inst.grp_id  <= i_disp_grp_id;
      r_inst.reg_tag <= i_disp.reg_tag;
      r_inst.oh_idx  <= i_queue_index;
    end
    if (i_ex2_valid && !i_ex2_update.tlb_miss) begin
      r_addr <= i_ex2_update.addr;
      r_data <= i_ex2_update.data;
    end
  end

  assign o_entry.state  = r_state;
  assign o_entry.cmt_id = r_inst.cmt_id;
  assign o_entry.grp_id = r_inst.grp_id;
  assign o_entry.inst   = r_inst;
  assign o_entry.addr   = r_addr;
  assign o_entry.data   = r_data;

  // Pipe results only for entries that were replayed
  a_ex2_in_issued: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_ex2_valid |-> r_state == msrh_lsu_pkg::ISSUED);

endmodule

// ==== rtl/msrh_stq.sv ====
`timescale 1ns/1ps
`include "msrh_params.svh"

module msrh_stq (
  input  logic                        i_clk,
  input  logic                        i_reset_n,

  input  logic [`MSRH_DISP_SIZE-1:0]  i_disp_valid,
  input  msrh_pkg::disp_grp_t         i_disp,
  output logic                        o_disp_ready,

  output logic                        o_replay_valid,
  output msrh_pkg::issue_t            o_replay_issue,
  input  logic                        i_replay_ready,
  input  msrh_lsu_pkg::ex2_q_update_t i_ex2_update,

  input  msrh_pkg::commit_blk_t       i_commit,
  output msrh_pkg::done_rpt_t         o_done_report,

  output msrh_lsu_pkg::drain_req_t    o_drain_req,
  input  logic                        i_drain_ready
);

  localparam int SIZE  = `MSRH_STQ_SIZE;
  localparam int PTR_W = $clog2(`MSRH_STQ_SIZE);
  localparam int CNT_W = PTR_W + 1;

  logic [`MSRH_MEM_DISP_SIZE-1:0]      w_pick_valid;
  msrh_pkg::disp_t                     w_pick[`MSRH_MEM_DISP_SIZE];
  logic [`MSRH_DISP_SIZE-1:0]          w_pick_grp_id[`MSRH_MEM_DISP_SIZE];
  logic [CNT_W-1:0]                    w_pick_num;

  msrh_lsu_pkg::stq_entry_t [SIZE-1:0] w_entries;
  logic [SIZE-1:0]                     w_ready_vec;
  logic [SIZE-1:0]                     w_ready_oh;
  logic [SIZE-1:0]                     w_done_vec;
  logic [SIZE-1:0]                     w_done_oh;
  msrh_lsu_pkg::stq_entry_t            w_replay_entry;
  msrh_lsu_pkg::stq_entry_t            w_done_entry;
  msrh_lsu_pkg::stq_entry_t            w_head;
  logic                                w_drain_fire;

  logic [PTR_W-1:0]                    r_in_ptr;
  logic [PTR_W-1:0]                    r_out_ptr;
  logic [CNT_W-1:0]                    r_count;

  function automatic logic [SIZE-1:0] lowest_oh(input logic [SIZE-1:0] vec);
    return vec & (~vec + SIZE'(1));
  endfunction

  function automatic msrh_lsu_pkg::stq_entry_t select_entry(
    input logic [SIZE-1:0]                     oh,
    input msrh_lsu_pkg::stq_entry_t [SIZE-1:0] entries
  );
    msrh_lsu_pkg::stq_entry_t sel;
    sel = '0;
    for (int i = 0; i < SIZE; i++) begin
      if (oh[i]) sel = entries[i];
    end
    return sel;
  endfunction

  msrh_disp_pickup u_msrh_disp_pickup (
    .i_disp_valid  (i_disp_valid),
    .i_disp        (i_disp),
    .o_pick_valid  (w_pick_valid),
    .o_pick        (w_pick),
    .o_pick_grp_id (w_pick_grp_id)
  );

  always_comb begin
    w_pick_num = '0;
    for (int p = 0; p < `MSRH_MEM_DISP_SIZE; p++) begin
      w_pick_num = w_pick_num + CNT_W'(w_pick_valid[p]);
    end
  end

  // ======================================================================
  // Pointers and occupancy
  // ======================================================================
  assign w_drain_fire = o_drain_req.valid && i_drain_ready;
  assign o_disp_ready = r_count <= CNT_W'(SIZE - `MSRH_MEM_DISP_SIZE);

  always_ff @(posedge i_clk) begin
    if (!i_reset_n) begin
      r_in_ptr  <= '0;
      r_out_ptr <= '0;
      r_count   <= '0;
    end else begin
      r_in_ptr  <= r_in_ptr + w_pick_num[PTR_W-1:0];
      r_out_ptr <= r_out_ptr + PTR_W'(w_drain_fire);
      r_count   <= r_count + w_pick_num - CNT_W'(w_drain_fire);
    end
  end

  // ======================================================================
  // Entries
  // ======================================================================
  generate
    for (genvar s = 0; s < SIZE; s++) begin : g_entry
      logic                       w_load;
      msrh_pkg::disp_t            w_disp;
      logic [`MSRH_DISP_SIZE-1:0] w_grp_id;

      // Write port p lands at in_ptr + p
      always_comb begin
        w_load   = 1'b0;
        w_disp   = '0;
        w_grp_id = '0;
        for (int p = 0; p < `MSRH_MEM_DISP_SIZE; p++) begin
          if (w_pick_valid[p] && (r_in_ptr + PTR_W'(p) == PTR_W'(s))) begin
            w_load   = 1'b1;
            w_disp   = w_pick[p];
            w_grp_id = w_pick_grp_id[p];
          end
        end
      end

      msrh_stq_entry u_msrh_stq_entry (
        .i_clk           (i_clk),
        .i_reset_n       (i_reset_n),
        .i_disp_load     (w_load),
        .i_disp_cmt_id   (i_disp.cmt_id),
        .i_disp_grp_id   (w_grp_id),
        .i_disp          (w_disp),
        .i_queue_index   (SIZE'(1) << s),
        .i_replay_accept (w_ready_oh[s] && i_replay_ready),
        .i_ex2_valid     (i_ex2_update.valid && i_ex2_update.index_oh[s]),
        .i_ex2_update    (i_ex2_update),
        .i_done_taken    (w_done_oh[s]),
        .i_commit        (i_commit),
        .i_drain_taken   (w_drain_fire && (r_out_ptr == PTR_W'(s))),
        .o_entry         (w_entries[s])
      );

      assign w_ready_vec[s] = w_entries[s].state == msrh_lsu_pkg::READY;
      assign w_done_vec[s]  = w_entries[s].state == msrh_lsu_pkg::ADDR_DONE;
    end
  endgenerate

  // Replay the lowest READY entry first
  assign w_ready_oh     = lowest_oh(w_ready_vec);
  assign w_replay_entry = select_entry(w_ready_oh, w_entries);
  assign o_replay_valid = |w_ready_vec;
  assign o_replay_issue = w_replay_entry.inst;

  // Done report is taken in the same cycle
  assign w_done_oh             = lowest_oh(w_done_vec);
  assign w_done_entry          = select_entry(w_done_oh, w_entries);
  assign o_done_report.valid   = |w_done_vec;
  assign o_done_report.cmt_id  = w_done_entry.cmt_id;
  assign o_done_report.grp_id  = w_done_entry.grp_id;
  assign o_done_report.exc_vld = 1'b0;

  // Head entry to the drain
  assign w_head            = w_entries[r_out_ptr];
  assign o_drain_req.valid = w_head.state == msrh_lsu_pkg::COMMIT;
  assign o_drain_req.addr  = w_head.addr;
  assign o_drain_req.data  = w_head.data;

  a_disp_when_ready: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    |i_disp_valid |-> o_disp_ready);
  a_count_bound: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    r_count <= CNT_W'(SIZE));

endmodule

// ==== rtl/msrh_store_drain.sv ====
`timescale 1ns/1ps
`include "msrh_params.svh"

module msrh_store_drain (
  input  logic                     i_clk,
  input  logic                     i_reset_n,

  input  msrh_lsu_pkg::drain_req_t i_drain_req,
  output logic                     o_drain_ready,

  output msrh_lsu_pkg::apb_req_t   o_apb,
  input  logic                     i_pready
);

  typedef enum logic [1:0] {
    IDLE,
    SETUP,
    ACCESS
  } apb_state_t;

  apb_state_t              r_state;
  logic [`MSRH_ADDR_W-1:0] r_addr;
  logic [`MSRH_DATA_W-1:0] r_data;
  logic                    w_accept;

  assign o_drain_ready = r_state == IDLE;
  assign w_accept      = i_drain_req.valid && o_drain_ready;

  always_ff @(posedge i_clk) begin
    if (!i_reset_n) begin
      r_state <= IDLE;
    end else begin
      unique case (r_state)
        IDLE:    if (w_accept) r_state <= SETUP;
        SETUP:   r_state <= ACCESS;
        ACCESS:  if (i_pready) r_state <= IDLE;
        default: r_state <= IDLE;
      endcase
    end
  end

  // Held for the whole transfer
  always_ff @(posedge i_clk) begin
    if (w_accept) begin
      r_addr <= i_drain_req.addr;
      r_data <= i_drain_req.data;
    end
  end

  assign o_apb.paddr   = r_addr;
  assign o_apb.pwdata  = r_data;
  assign o_apb.psel    = r_state != IDLE;
  assign o_apb.penable = r_state == ACCESS;
  assign o_apb.pwrite  = 1'b1;

  a_penable_psel: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_apb.penable |-> o_apb.psel);
  a_apb_stable: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (o_apb.psel && !(o_apb.penable && i_pready)) |=>
      ($stable(o_apb.paddr) && $stable(o_apb.pwdata)));

endmodule

// ==== rtl/msrh_store_unit.sv ====
`timescale 1ns/1ps
`include "msrh_params.svh"

module msrh_store_unit (
  input  logic                        i_clk,
  input  logic                        i_reset_n,

  input  logic [`MSRH_DISP_SIZE-1:0]  i_disp_valid,
  input  msrh_pkg::disp_grp_t         i_disp,
  output logic                        o_disp_ready,

  output logic                        o_replay_valid,
  output msrh_pkg::issue_t            o_replay_issue,
  input  logic                        i_replay_ready,
  input  msrh_lsu_pkg::ex2_q_update_t i_ex2_update,

  input  msrh_pkg::commit_blk_t       i_commit,
  output msrh_pkg::done_rpt_t         o_done_report,

  output msrh_lsu_pkg::apb_req_t      o_apb,
  input  logic                        i_pready
);

  msrh_lsu_pkg::drain_req_t w_drain_req;
  logic                     w_drain_ready;

  msrh_stq u_msrh_stq (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_disp_valid   (i_disp_valid),
    .i_disp         (i_disp),
    .o_disp_ready   (o_disp_ready),
    .o_replay_valid (o_replay_valid),
    .o_replay_issue (o_replay_issue),
    .i_replay_ready (i_replay_ready),
    .i_ex2_update   (i_ex2_update),
    .i_commit       (i_commit),
    .o_done_report  (o_done_report),
    .o_drain_req    (w_drain_req),
    .i_drain_ready  (w_drain_ready)
  );

  msrh_store_drain u_msrh_store_drain (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_drain_req   (w_drain_req),
    .o_drain_ready (w_drain_ready),
    .o_apb         (o_apb),
    .i_pready      (i_pready)
  );

endmodule

// ==== testbench/tb_msrh_store_unit.sv ====
`timescale 1ns/1ps
`include "msrh_params.svh"

module tb_msrh_store_unit;

  localparam int NUM_LINES   = 16;
  localparam int NUM_GROUPS  = NUM_LINES / 2;
  localparam int STALL_CYC   = 60;
  localparam int CYCLE_LIMIT = 200 + 60 * NUM_LINES;

  logic                        i_clk;
  logic                        i_reset_n;
  logic [`MSRH_DISP_SIZE-1:0]  i_disp_valid;
  msrh_pkg::disp_grp_t         i_disp;
  logic                        o_disp_ready;
  logic                        o_replay_valid;
  msrh_pkg::issue_t            o_replay_issue;
  logic                        i_replay_ready;
  msrh_lsu_pkg::ex2_q_update_t i_ex2_update;
  msrh_pkg::commit_blk_t       i_commit;
  msrh_pkg::done_rpt_t         o_done_report;
  msrh_lsu_pkg::apb_req_t      o_apb;
  logic                        i_pready;

  // Four words per store for slot, address, data and miss flag
  logic [31:0] file_mem [0:4*NUM_LINES-1];
  int          replays [NUM_LINES];
  bit          done_seen [NUM_LINES];
  bit          committed [NUM_GROUPS];
  int          disp_grp, cmt_grp, wr_idx, stall_left, stall_accepts, wait_cnt, errors;
  int          cycle_cnt = 0;
  logic [31:0] rnd;
  msrh_lsu_pkg::ex2_q_update_t pend_upd, pipe_upd;

  msrh_store_unit UUT (.*);

  initial i_clk = 1'b0;
  always #4 i_clk = ~i_clk;

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic int find_line(input logic [`MSRH_CMT_ID_W-1:0] cmt,
                                   input logic [`MSRH_DISP_SIZE-1:0] grp);
    int l;
    for (int k = 0; k < 2; k++) begin
      l = 2 * int'(cmt) + k;
      if (l < NUM_LINES && grp == (`MSRH_DISP_SIZE'(1) << file_mem[4*l][0])) return l;
    end
    return -1;
  endfunction

  // ======================================================================
  // Error reporting and compare tasks
  // ======================================================================
  task automatic report_error(input string msg);
    errors++;
    $display("%s", msg);
    $display("tests failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_bit(input string name, input logic act, input logic exp);
    if (act !== exp)
      report_error($sformatf("mismatch at %0t: %s expected %b got %b", $time, name, exp, act));
  endtask

  task automatic check_count(input string name, input int act, input int exp);
    if (act != exp)
      report_error($sformatf("mismatch at %0t: %s expected %0d got %0d", $time, name, exp, act));
  endtask

  task automatic check_replay(input string name, input msrh_pkg::issue_t act,
                              input msrh_pkg::issue_t exp);
    if (act !== exp)
      report_error($sformatf("mismatch at %0t: %s expected %h got %h", $time, name, exp, act));
  endtask

  task automatic check_done(input string name, input msrh_pkg::done_rpt_t act,
                            input msrh_pkg::done_rpt_t exp);
    if (act !== exp)
      report_error($sformatf("mismatch at %0t: %s expected %h got %h", $time, name, exp, act));
  endtask

  task automatic check_apb(input string name, input msrh_lsu_pkg::apb_req_t act,
                           input msrh_lsu_pkg::apb_req_t exp);
    if (act !== exp)
      report_error($sformatf("mismatch at %0t: %s expected %h got %h", $time, name, exp, act));
  endtask

  always @(posedge i_clk) begin
    cycle_cnt++;
    if (cycle_cnt >= CYCLE_LIMIT)
      report_error($sformatf("timeout: only %0d of %0d stores written after %0d cycles",
                             wr_idx, NUM_LINES, cycle_cnt));
  end

  // ======================================================================
  // Input drivers for dispatch, LSU pipe, commit and APB slave
  // ======================================================================
  always @(posedge i_clk) begin : drive_inputs
    int line;
    int slot;
    if (i_reset_n) begin
      #1;
      i_disp_valid = '0;
      i_disp       = '0;
      if (o_disp_ready && disp_grp < NUM_GROUPS) begin
        for (int k = 0; k < 2; k++) begin
          line = 2 * disp_grp + k;
          slot = int'(file_mem[4*line][0]);
          i_disp_valid[slot]       = 1'b1;
          i_disp.inst[slot].store  = 1'b1;
          i_disp.inst[slot].reg_tag = `MSRH_REG_TAG_W'(line);
          if (stall_left > 0) stall_accepts++;
        end
        i_disp.cmt_id = `MSRH_CMT_ID_W'(disp_grp);
        disp_grp++;
      end
      // Two-stage pipe back to EX2
      i_ex2_update = pipe_upd;
      pipe_upd     = pend_upd;
      pend_upd     = '0;
      if (stall_left > 0) begin
        i_replay_ready = 1'b0;
        stall_left--;
      end else begin
        rnd = lcg_step(rnd);
        i_replay_ready = rnd[17:16] != 2'b00;
      end
      // In-order commit once both stores of a group are done
      i_commit = '0;
      if (cmt_grp < NUM_GROUPS && done_seen[2*cmt_grp] && done_seen[2*cmt_grp+1]) begin
        i_commit.valid  = 1'b1;
        i_commit.cmt_id = `MSRH_CMT_ID_W'(cmt_grp);
        i_commit.grp_id = '1;
        committed[cmt_grp] = 1'b1;
        cmt_grp++;
      end
      if (o_apb.psel && o_apb.penable) begin
        if (wait_cnt == 0) begin
          i_pready = 1'b1;
        end else begin
          i_pready = 1'b0;
          wait_cnt--;
        end
      end else begin
        i_pready = 1'b0;
        rnd      = lcg_step(rnd);
        wait_cnt = int'(rnd[21:20]);
      end
    end
  end

  // Outputs sampled mid-cycle
  always @(negedge i_clk) begin : watch_outputs
    int                     line;
    msrh_pkg::issue_t       exp_issue;
    msrh_pkg::done_rpt_t    exp_done;
    msrh_lsu_pkg::apb_req_t exp_apb;
    if (i_reset_n) begin
      if (o_replay_valid && i_replay_ready) begin
        // The register tag carries the line number
        line = int'(o_replay_issue.reg_tag);
        if (line >= 2 * disp_grp) begin
          report_error("replay of a store that was never dispatched");
        end else begin
          exp_issue.cmt_id  = `MSRH_CMT_ID_W'(line / 2);
          exp_issue.grp_id  = `MSRH_DISP_SIZE'(1) << file_mem[4*line][0];
          exp_issue.reg_tag = `MSRH_REG_TAG_W'(line);
          // Entries fill in ring order with one store each
          exp_issue.oh_idx  = `MSRH_STQ_SIZE'(1) << (line % `MSRH_STQ_SIZE);
          check_replay("o_replay_issue", o_replay_issue, exp_issue);
          pend_upd.valid    = 1'b1;
          pend_upd.index_oh = o_replay_issue.oh_idx;
          pend_upd.tlb_miss = file_mem[4*line+3][0] && replays[line] == 0;
          pend_upd.addr     = file_mem[4*line+1];
          pend_upd.data     = file_mem[4*line+2];
          replays[line]++;
        end
      end
      if (o_done_report.valid) begin
        line = find_line(o_done_report.cmt_id, o_done_report.grp_id);
        if (line < 0) begin
          report_error("done report for a store that was never dispatched");
        end else if (done_seen[line]) begin
          report_error($sformatf("store %0d was reported done twice", line));
        end else begin
          check_count("replays before done", replays[line], 1 + int'(file_mem[4*line+3][0]));
          exp_done.valid   = 1'b1;
          exp_done.cmt_id  = `MSRH_CMT_ID_W'(line / 2);
          exp_done.grp_id  = `MSRH_DISP_SIZE'(1) << file_mem[4*line][0];
          exp_done.exc_vld = 1'b0;
          check_done("o_done_report", o_done_report, exp_done);
          done_seen[line] = 1'b1;
        end
      end
      if (o_apb.psel && o_apb.penable && i_pready) begin
        if (wr_idx >= NUM_LINES) begin
          report_error("more APB writes than stores in the input file");
        end else if (!committed[wr_idx/2]) begin
          report_error($sformatf("APB write of store %0d before its group committed", wr_idx));
        end else begin
          exp_apb.paddr   = file_mem[4*wr_idx+1];
          exp_apb.pwdata  = file_mem[4*wr_idx+2];
          exp_apb.psel    = 1'b1;
          exp_apb.penable = 1'b1;
          exp_apb.pwrite  = 1'b1;
          check_apb("o_apb", o_apb, exp_apb);
          wr_idx++;
        end
      end
    end
  end

  initial begin
    $readmemh("testbench/stq_input.txt", file_mem);
    rnd = 32'h68799205;
    i_reset_n = 1'b0;
    i_disp_valid = '0;
    i_disp = '0;
    i_replay_ready = 1'b0;
    i_ex2_update = '0;
    i_commit = '0;
    i_pready = 1'b0;
    pend_upd = '0;
    pipe_upd = '0;
    for (int l = 0; l < NUM_LINES; l++) begin
      replays[l] = 0;
      done_seen[l] = 1'b0;
    end
    repeat (8) @(posedge i_clk);
    #1;
    check_bit("o_replay_valid", o_replay_valid, 1'b0);
    check_bit("o_done_report.valid", o_done_report.valid, 1'b0);
    check_bit("o_apb.psel", o_apb.psel, 1'b0);
    check_bit("o_apb.penable", o_apb.penable, 1'b0);
    check_bit("o_disp_ready", o_disp_ready, 1'b1);
    stall_left = STALL_CYC;
    i_reset_n = 1'b1;
    // With replay stalled nothing drains, so groups of two fill the queue
    wait (stall_left == 0);
    check_count("stores accepted while replay stalled", stall_accepts, `MSRH_STQ_SIZE);
    check_bit("o_disp_ready", o_disp_ready, 1'b0);
    while (wr_idx < NUM_LINES) @(posedge i_clk);
    for (int l = 0; l < NUM_LINES; l++) begin
      check_count($sformatf("replays of store %0d", l), replays[l],
                  1 + int'(file_mem[4*l+3][0]));
      check_bit($sformatf("done of store %0d", l), done_seen[l], 1'b1);
    end
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// ==== testbench/stq_input.txt ====
// Columns are slot, address, data and tlb_miss_once
// Each pair of lines is one dispatch group
0 80000000 a5a50001 0
1 80000004 5a5a0002 1
0 80000010 deadbeef 0
1 8000001c 01234567 0
0 80000020 89abcdef 1
1 80000028 13579bdf 0
0 80000100 2468ace0 0
1 80000104 fedcba98 1
0 80000200 0f0f0f0f 0
1 80000208 f0f0f0f0 0
0 80000300 76543210 1
1 8000030c 3c3c3c3c 1
0 80000400 c3c3c3c3 0
1 80000404 0badf00d 0
0 80000500 cafe0123 1
1 80000510 11223344 0

// ==== vlog.f ====
+incdir+rtl
rtl/msrh_pkg.sv
rtl/msrh_lsu_pkg.sv
rtl/msrh_disp_pickup.sv
rtl/msrh_stq_entry.sv
rtl/msrh_stq.sv
rtl/msrh_store_drain.sv
rtl/msrh_store_unit.sv
testbench/tb_msrh_store_unit.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f vlog.f \
  --top-module tb_msrh_store_unit -o tb_sim > build.log 2>&1 \
  && ./obj_dir/tb_sim > sim.log 2>&1 \
  || echo "build or simulation ended with an error"
cat sim.log 2>/dev/null
grep -qx "all tests passed" sim.log 2>/dev/null \
  && echo "PASS" \
  || { echo "FAIL"; exit 1; }
